//--- bench/core_stimulus.txt
// Columns (hex): pc, instruction word, expected wnum, expected wen, expected wdata
// Expected values apply the ALU rules in order, starting from all registers zero
00001000 E1000123 01 1 12300000
00001004 C20007FF 02 1 000007FF
00001008 C3000800 03 1 FFFFF800
0000100C 04088000 04 1 123007FF
00001010 2510C000 05 1 00000FFF
00001014 4620C000 06 1 12300000
00001018 67104000 07 1 123007FF
0000101C 88214000 08 1 12300800
00001020 A9188000 09 1 00000001
00001024 AA10C000 0A 1 00000000
00001028 C0080055 00 0 12300055
0000102C 0B008000 0B 1 000007FF
00001030 EC000FFF 0C 1 FFF00000
00001034 2D030000 0D 1 00100000
00001038 CE000001 0E 1 00000001
0000103C 0E738000 0E 1 00000002
00001040 0F738000 0F 1 00000004
00001044 1073C000 10 1 00000006
00001048 3183B000 11 1 00000004
0000104C 928BC000 12 1 00000000
00001050 B31C4000 13 1 00000001
00001054 74980000 14 1 00000001
00001058 C0A007FF 00 0 00000800
0000105C 15050000 15 1 00000001
00001060 56A9C000 16 1 00000001
00001064 F7000800 17 1 80000000
00001068 B8BD8000 18 1 00000001
0000106C 39BE0000 19 1 7FFFFFFF

//--- bench/tb_cpu_core.sv
module tb_cpu_core;

    localparam int BUF_DEPTH   = 8;
    localparam int NUM_ENTRIES = 28;
    localparam int FIELDS      = 5;   // pc, instr, wnum, wen, wdata
    localparam int BURST_FIRST = 14;  // From here on no idle gaps
    localparam int TIMEOUT     = 50;
    localparam int RST_CYCLES  = 10;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        instr_ready_o;
    logic        debug_wb_valid_o;
    logic [31:0] debug_wb_pc_o;
    logic        debug_wb_rf_wen_o;
    logic [4:0]  debug_wb_rf_wnum_o;
    logic [31:0] debug_wb_rf_wdata_o;

    logic [31:0] stim_mem [NUM_ENTRIES*FIELDS];
    logic [31:0] lfsr_state = 32'h4ad5678d;

    always #5 clk = ~clk;

    cpu_core #(
        .BUF_DEPTH(BUF_DEPTH)
    ) cpu_core_i (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .instr_valid_i       (instr_valid_i),
        .instr_i             (instr_i),
        .pc_i                (pc_i),
        .instr_ready_o       (instr_ready_o),
        .debug_wb_valid_o    (debug_wb_valid_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Holds the entry on the inputs until the buffer takes it
    task automatic push_entry(input int idx);
        int cycles;
        cycles = 0;
        instr_valid_i <= 1'b1;
        pc_i          <= stim_mem[idx*FIELDS];
        instr_i       <= stim_mem[idx*FIELDS+1];
        @(posedge clk);
        while (instr_ready_o !== 1'b1) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("instruction %0d was not accepted within timeout", idx);
                $display("Testbench failed");
                $fatal(1, "push timeout");
            end
            @(posedge clk);
        end
    endtask

    task automatic drive_all();
        int gap;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            gap = 0;
            if (i < BURST_FIRST) begin
                gap[0]     = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
                gap[1]     = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
            repeat (gap) begin
                instr_valid_i <= 1'b0;
                @(posedge clk);
            end
            push_entry(i);
        end
        instr_valid_i <= 1'b0;
    endtask

    task automatic wait_commit(input int idx);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (debug_wb_valid_o !== 1'b1) begin
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("no commit within timeout for entry %0d", idx);
                $display("Testbench failed");
                $fatal(1, "commit timeout");
            end
            @(posedge clk);
        end
    endtask

    task automatic monitor_all();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            wait_commit(i);
            check_value("debug_wb_pc_o", debug_wb_pc_o, stim_mem[i*FIELDS]);
            check_value("debug_wb_rf_wnum_o", debug_wb_rf_wnum_o, stim_mem[i*FIELDS+2]);
            check_value("debug_wb_rf_wen_o", debug_wb_rf_wen_o, stim_mem[i*FIELDS+3]);
            check_value("debug_wb_rf_wdata_o", debug_wb_rf_wdata_o, stim_mem[i*FIELDS+4]);
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;

        $readmemh("bench/core_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[NUM_ENTRIES*FIELDS-1])) begin
            $display("stimulus file is missing or has too few entries");
            $display("Testbench failed");
            $fatal(1, "bad stimulus file");
        end

        repeat (RST_CYCLES) @(posedge clk);
        check_value("instr_ready_o", instr_ready_o, 32'd1);
        check_value("debug_wb_valid_o", debug_wb_valid_o, 32'd0);
        rst_n_i <= 1'b1;

        fork
            drive_all();
            monitor_all();
        join

        // Nothing may retire twice
        repeat (10) begin
            @(posedge clk);
            check_value("debug_wb_valid_o", debug_wb_valid_o, 32'd0);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- src/commit_trace.sv
module commit_trace (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            wb_valid_i,
    input  logic                            wb_wen_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [core_pkg::XLEN-1:0]       wb_data_i,
    input  logic [core_pkg::XLEN-1:0]       wb_pc_i,

    output logic                            debug_wb_valid_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic                            debug_wb_rf_wen_o,
    output logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            debug_wb_valid_o <= 1'b0;
        end else begin
            debug_wb_valid_o <= wb_valid_i;  // One-cycle pulse per retirement
        end
    end

    // Fields keep the last retirement
    always_ff @(posedge clk) begin
        if (wb_valid_i) begin
            debug_wb_pc_o       <= wb_pc_i;
            debug_wb_rf_wen_o   <= wb_wen_i;
            debug_wb_rf_wnum_o  <= wb_rd_i;
            debug_wb_rf_wdata_o <= wb_data_i;
        end
    end

endmodule

//--- src/core_pkg.sv
package core_pkg;

    // Datapath and fetch widths
    localparam int XLEN       = 32;
    localparam int INSTR_W    = 32;

    // Architectural register file
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Instruction word layout
    //   31:29 opcode
    //   28:24 rd
    //   23:19 rj
    //   18:14 rk
    //   13:12 unused
    //   11:0  imm12
    localparam int OPC_W      = 3;
    localparam int OPC_LSB    = 29;
    localparam int RD_LSB     = 24;
    localparam int RJ_LSB     = 19;
    localparam int RK_LSB     = 14;
    localparam int IMM_W      = 12;

    // LUI places imm12 in the upper bits
    localparam int LUI_SHIFT  = 20;

    // Opcode values double as the ALU operation select
    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 3'd0,  // rj + rk
        OP_SUB  = 3'd1,  // rj - rk
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLT  = 3'd5,  // Signed, result is 1 or 0
        OP_ADDI = 3'd6,  // rj + sext(imm12)
        OP_LUI  = 3'd7   // imm12 << 20
    } alu_op_e;

endpackage

//--- src/cpu_core.sv
module cpu_core #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            instr_valid_i,
    input  logic [core_pkg::INSTR_W-1:0]    instr_i,
    input  logic [core_pkg::XLEN-1:0]       pc_i,
    output logic                            instr_ready_o,

    output logic                            debug_wb_valid_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_pc_o,
    output logic                            debug_wb_rf_wen_o,
    output logic [core_pkg::REG_ADDR_W-1:0] debug_wb_rf_wnum_o,
    output logic [core_pkg::XLEN-1:0]       debug_wb_rf_wdata_o
);

    import core_pkg::*;

    logic                  buf_valid;
    logic [INSTR_W-1:0]    buf_instr;
    logic [XLEN-1:0]       buf_pc;
    logic                  buf_pop;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    logic                  iss_valid;
    alu_op_e               iss_op;
    logic [XLEN-1:0]       iss_a;
    logic [XLEN-1:0]       iss_b;
    logic [REG_ADDR_W-1:0] iss_rd;
    logic                  iss_wen;
    logic [XLEN-1:0]       iss_pc;

    logic                  ex_fwd_valid;
    logic [REG_ADDR_W-1:0] ex_fwd_rd;
    logic [XLEN-1:0]       ex_fwd_data;

    logic                  wb_valid;
    logic                  wb_wen;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       wb_pc;

    instr_buffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) u_instr_buffer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .push_valid_i (instr_valid_i),
        .push_instr_i (instr_i),
        .push_pc_i    (pc_i),
        .push_ready_o (instr_ready_o),
        .pop_i        (buf_pop),
        .head_valid_o (buf_valid),
        .head_instr_o (buf_instr),
        .head_pc_o    (buf_pc)
    );

    issue_unit u_issue_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head_valid_i   (buf_valid),
        .head_instr_i   (buf_instr),
        .head_pc_i      (buf_pc),
        .pop_o          (buf_pop),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .ex_fwd_valid_i (ex_fwd_valid),
        .ex_fwd_rd_i    (ex_fwd_rd),
        .ex_fwd_data_i  (ex_fwd_data),
        .iss_valid_o    (iss_valid),
        .iss_op_o       (iss_op),
        .iss_a_o        (iss_a),
        .iss_b_o        (iss_b),
        .iss_rd_o       (iss_rd),
        .iss_wen_o      (iss_wen),
        .iss_pc_o       (iss_pc)
    );

    // Written from the write-back register
    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .we_i     (wb_wen),
        .waddr_i  (wb_rd),
        .wdata_i  (wb_data)
    );

    exec_unit u_exec_unit (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .iss_valid_i    (iss_valid),
        .iss_op_i       (iss_op),
        .iss_a_i        (iss_a),
        .iss_b_i        (iss_b),
        .iss_rd_i       (iss_rd),
        .iss_wen_i      (iss_wen),
        .iss_pc_i       (iss_pc),
        .ex_fwd_valid_o (ex_fwd_valid),
        .ex_fwd_rd_o    (ex_fwd_rd),
        .ex_fwd_data_o  (ex_fwd_data),
        .wb_valid_o     (wb_valid),
        .wb_wen_o       (wb_wen),
        .wb_rd_o        (wb_rd),
        .wb_data_o      (wb_data),
        .wb_pc_o        (wb_pc)
    );

    commit_trace u_commit_trace (
        .clk                 (clk),
        .rst_n_i             (rst_n_i),
        .wb_valid_i          (wb_valid),
        .wb_wen_i            (wb_wen),
        .wb_rd_i             (wb_rd),
        .wb_data_i           (wb_data),
        .wb_pc_i             (wb_pc),
        .debug_wb_valid_o    (debug_wb_valid_o),
        .debug_wb_pc_o       (debug_wb_pc_o),
        .debug_wb_rf_wen_o   (debug_wb_rf_wen_o),
        .debug_wb_rf_wnum_o  (debug_wb_rf_wnum_o),
        .debug_wb_rf_wdata_o (debug_wb_rf_wdata_o)
    );

endmodule

//--- src/exec_unit.sv
module exec_unit (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            iss_valid_i,
    input  core_pkg::alu_op_e               iss_op_i,
    input  logic [core_pkg::XLEN-1:0]       iss_a_i,
    input  logic [core_pkg::XLEN-1:0]       iss_b_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] iss_rd_i,
    input  logic                            iss_wen_i,
    input  logic [core_pkg::XLEN-1:0]       iss_pc_i,

    // Back to issue
    output logic                            ex_fwd_valid_o,
    output logic [core_pkg::REG_ADDR_W-1:0] ex_fwd_rd_o,
    output logic [core_pkg::XLEN-1:0]       ex_fwd_data_o,

    // Write-back register
    output logic                            wb_valid_o,
    output logic                            wb_wen_o,
    output logic [core_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [core_pkg::XLEN-1:0]       wb_data_o,
    output logic [core_pkg::XLEN-1:0]       wb_pc_o
);

    import core_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic            slt;

    assign slt = ($signed(iss_a_i) < $signed(iss_b_i));

    always_comb begin
        case (iss_op_i)
            OP_ADD,
            OP_ADDI: alu_result = iss_a_i + iss_b_i;  // Immediate already in b
            OP_SUB:  alu_result = iss_a_i - iss_b_i;
            OP_AND:  alu_result = iss_a_i & iss_b_i;
            OP_OR:   alu_result = iss_a_i | iss_b_i;
            OP_XOR:  alu_result = iss_a_i ^ iss_b_i;
            OP_SLT:  alu_result = {{(XLEN-1){1'b0}}, slt};
            OP_LUI:  alu_result = iss_b_i;
            default: alu_result = '0;
        endcase
    end

    assign ex_fwd_valid_o = iss_valid_i && iss_wen_i;
    assign ex_fwd_rd_o    = iss_rd_i;
    assign ex_fwd_data_o  = alu_result;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
            wb_wen_o   <= 1'b0;
        end else begin
            wb_valid_o <= iss_valid_i;
            wb_wen_o   <= iss_valid_i && iss_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid_i) begin
            wb_rd_o   <= iss_rd_i;
            wb_data_o <= alu_result;
            wb_pc_o   <= iss_pc_i;
        end
    end

    // Issue raises the write enable only together with valid
    a_wen_needs_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        iss_wen_i |-> iss_valid_i);

endmodule

//--- src/instr_buffer.sv
module instr_buffer #(
    parameter int BUF_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst_n_i,

    input  logic                         push_valid_i,
    input  logic [core_pkg::INSTR_W-1:0] push_instr_i,
    input  logic [core_pkg::XLEN-1:0]    push_pc_i,
    output logic                         push_ready_o,

    input  logic                         pop_i,
    output logic                         head_valid_o,
    output logic [core_pkg::INSTR_W-1:0] head_instr_o,
    output logic [core_pkg::XLEN-1:0]    head_pc_o
);

    import core_pkg::*;

    localparam int PTR_W = $clog2(BUF_DEPTH);

    logic [INSTR_W-1:0] instr_mem [BUF_DEPTH];
    logic [XLEN-1:0]    pc_mem    [BUF_DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;  // One bit wider to hold BUF_DEPTH

    logic               do_push;
    logic               do_pop;

    assign push_ready_o = (count != (PTR_W+1)'(BUF_DEPTH));
    assign head_valid_o = (count != '0);
    assign do_push      = push_valid_i && push_ready_o;
    assign do_pop       = pop_i;

    assign head_instr_o = instr_mem[rd_ptr];
    assign head_pc_o    = pc_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= push_instr_i;
            pc_mem[wr_ptr]    <= push_pc_i;
        end
    end

    // Issue side must only pop a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
        pop_i |-> count != '0);

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count <= BUF_DEPTH);

endmodule

//--- src/issue_unit.sv
module issue_unit (
    input  logic                            clk,
    input  logic                            rst_n_i,

    // Buffer head
    input  logic                            head_valid_i,
    input  logic [core_pkg::INSTR_W-1:0]    head_instr_i,
    input  logic [core_pkg::XLEN-1:0]       head_pc_i,
    output logic                            pop_o,

    // Register file read ports
    output logic [core_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [core_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [core_pkg::XLEN-1:0]       rs2_data_i,

    // Result of the instruction in execute
    input  logic                            ex_fwd_valid_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] ex_fwd_rd_i,
    input  logic [core_pkg::XLEN-1:0]       ex_fwd_data_i,

    // Issue register
    output logic                            iss_valid_o,
    output core_pkg::alu_op_e               iss_op_o,
    output logic [core_pkg::XLEN-1:0]       iss_a_o,
    output logic [core_pkg::XLEN-1:0]       iss_b_o,
    output logic [core_pkg::REG_ADDR_W-1:0] iss_rd_o,
    output logic                            iss_wen_o,
    output logic [core_pkg::XLEN-1:0]       iss_pc_o
);

    import core_pkg::*;

    alu_op_e               dec_op;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [IMM_W-1:0]      dec_imm;
    logic [XLEN-1:0]       rj_val;
    logic [XLEN-1:0]       rk_val;
    logic [XLEN-1:0]       op_b;

    // Never stalls, so the head is taken as soon as it shows up
    assign pop_o = head_valid_i;

    assign dec_op     = alu_op_e'(head_instr_i[OPC_LSB +: OPC_W]);
    assign dec_rd     = head_instr_i[RD_LSB +: REG_ADDR_W];
    assign rs1_addr_o = head_instr_i[RJ_LSB +: REG_ADDR_W];
    assign rs2_addr_o = head_instr_i[RK_LSB +: REG_ADDR_W];
    assign dec_imm    = head_instr_i[IMM_W-1:0];

    // Execute result wins over the register file value
    assign rj_val = (ex_fwd_valid_i && ex_fwd_rd_i == rs1_addr_o) ? ex_fwd_data_i : rs1_data_i;
    assign rk_val = (ex_fwd_valid_i && ex_fwd_rd_i == rs2_addr_o) ? ex_fwd_data_i : rs2_data_i;

    always_comb begin
        case (dec_op)
            OP_ADDI: op_b = {{(XLEN-IMM_W){dec_imm[IMM_W-1]}}, dec_imm};
            OP_LUI:  op_b = XLEN'(dec_imm) << LUI_SHIFT;
            default: op_b = rk_val;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iss_valid_o <= 1'b0;
            iss_wen_o   <= 1'b0;
        end else begin
            iss_valid_o <= head_valid_i;
            iss_wen_o   <= head_valid_i && (dec_rd != '0);  // r0 writes are dropped here
        end
    end

    always_ff @(posedge clk) begin
        if (head_valid_i) begin
            iss_op_o <= dec_op;
            iss_a_o  <= rj_val;
            iss_b_o  <= op_b;
            iss_rd_o <= dec_rd;
            iss_pc_o <= head_pc_i;
        end
    end

endmodule

//--- src/regfile.sv
module regfile (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic [core_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o,

    input  logic                            we_i,
    input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [core_pkg::XLEN-1:0]       wdata_i
);

    import core_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r0 first, then the write-back bypass
    assign rdata1_o = (raddr1_i == '0)                ? '0      :
                      (we_i && waddr_i == raddr1_i)   ? wdata_i :
                                                        regs[raddr1_i];

    assign rdata2_o = (raddr2_i == '0)                ? '0      :
                      (we_i && waddr_i == raddr2_i)   ? wdata_i :
                                                        regs[raddr2_i];

    // Issue clears the write enable for rd 0
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        we_i |-> waddr_i != '0);

endmodule

//--- vlog.f
src/core_pkg.sv
src/instr_buffer.sv
src/issue_unit.sv
src/regfile.sv
src/exec_unit.sv
src/commit_trace.sv
src/cpu_core.sv
bench/tb_cpu_core.sv
